//--- common/cpu_pkg.sv
package cpu_pkg;

  //////////////////////////////////////////////////
  // widths
  //////////////////////////////////////////////////

  typedef logic [31:0] data_t;
  typedef logic [31:0] instr_t;
  typedef logic [15:0] addr_t;
  typedef logic [4:0]  reg_idx_t;
  typedef logic [15:0] imm_t;

  // instruction fields
  localparam int OPC_MSB = 31;
  localparam int OPC_LSB = 26;
  localparam int RS_LSB  = 21;
  localparam int RT_LSB  = 16;
  localparam int RD_LSB  = 11;

  typedef enum logic [5:0] {
    op_nop  = 6'd0,
    op_add,
    op_sub,
    op_and,
    op_or,
    op_slt,
    op_addi,
    op_ori,
    op_lw,
    op_sw,
    op_beq,
    op_bne,
    op_jmp,
    op_halt
  } opcode_e;

  typedef enum logic [2:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_slt
  } alu_op_e;

  typedef enum logic [1:0] {
    fwd_reg,
    fwd_ex_mem,
    fwd_mem_wb
  } fwd_sel_e;

  //////////////////////////////////////////////////
  // pipeline records
  //////////////////////////////////////////////////

  typedef struct packed {
    alu_op_e alu_op;
    logic    alu_src_imm;
    logic    reg_write;
    logic    mem_read;
    logic    mem_write;
    logic    branch_eq;
    logic    branch_ne;
    logic    jump;
    logic    halt;
  } ctrl_t;

  // what still matters after execute
  typedef struct packed {
    logic reg_write;
    logic mem_read;
    logic mem_write;
    logic halt;
  } mem_ctrl_t;

  typedef struct packed {
    logic   valid;
    addr_t  pc;
    instr_t instr;
  } if_id_t;

  typedef struct packed {
    logic     valid;
    ctrl_t    ctrl;
    reg_idx_t rs;
    reg_idx_t rt;
    reg_idx_t dst;
    data_t    rs_data;
    data_t    rt_data;
    imm_t     imm;
  } id_ex_t;

  typedef struct packed {
    logic      valid;
    mem_ctrl_t ctrl;
    reg_idx_t  dst;
    data_t     alu_result;
    data_t     store_data;
  } ex_mem_t;

  typedef struct packed {
    logic  taken;
    addr_t target;
  } redirect_t;

  typedef struct packed {
    logic     valid;
    reg_idx_t dst;
    data_t    data;
  } retire_t;

endpackage

//--- fetch/fetch_stage.sv
module fetch_stage import cpu_pkg::*; #(
  parameter int IMEM_DEPTH = 256
) (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      imem_we,
  input  addr_t     imem_addr,
  input  instr_t    imem_wdata,
  input  logic      stall,
  input  redirect_t redirect,
  input  logic      halt_seen,
  output if_id_t    if_id
);

  localparam int IMEM_AW = $clog2(IMEM_DEPTH);

  addr_t  pc;
  instr_t imem [IMEM_DEPTH];
  instr_t fetched;

  //////////////////////////////////////////////////
  // instruction memory
  //////////////////////////////////////////////////

  // program load port, one word per cycle
  always_ff @(posedge clk) begin
    if (imem_we) begin
      imem[imem_addr[IMEM_AW-1:0]] <= imem_wdata;
    end
  end

  assign fetched = imem[pc[IMEM_AW-1:0]];

  //////////////////////////////////////////////////
  // program counter
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc <= '0;
    end else if (redirect.taken) begin
      pc <= redirect.target;
    end else if (!stall && !halt_seen) begin
      pc <= pc + addr_t'(1);
    end
  end

  // if/id, held on stall, emptied past a halt
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      if_id <= '0;
    end else if (redirect.taken) begin
      if_id.valid <= 1'b0;
    end else if (!stall) begin
      if_id.valid <= !halt_seen;
      if_id.pc    <= pc;
      if_id.instr <= fetched;
    end
  end

endmodule

//--- decode/decode_stage.sv
module decode_stage import cpu_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  if_id_t    if_id,
  input  retire_t   wb,
  input  redirect_t redirect,
  output id_ex_t    id_ex,
  output logic      stall,
  output logic      halt_seen
);

  opcode_e  opcode;
  reg_idx_t rs;
  reg_idx_t rt;
  reg_idx_t rd;
  ctrl_t    ctrl;
  id_ex_t   id_ex_d;
  logic     is_halt;
  logic     halt_q;
  data_t    regs [32];

  assign opcode = opcode_e'(if_id.instr[OPC_MSB:OPC_LSB]);
  assign rs     = if_id.instr[RS_LSB +: 5];
  assign rt     = if_id.instr[RT_LSB +: 5];
  assign rd     = if_id.instr[RD_LSB +: 5];

  function automatic ctrl_t decode_ctrl(opcode_e op);
    ctrl_t c;
    c        = '0;
    c.alu_op = alu_add;
    case (op)
      op_add:  c.reg_write = 1'b1;
      op_sub: begin
        c.alu_op    = alu_sub;
        c.reg_write = 1'b1;
      end
      op_and: begin
        c.alu_op    = alu_and;
        c.reg_write = 1'b1;
      end
      op_or: begin
        c.alu_op    = alu_or;
        c.reg_write = 1'b1;
      end
      op_slt: begin
        c.alu_op    = alu_slt;
        c.reg_write = 1'b1;
      end
      op_addi: begin
        c.alu_src_imm = 1'b1;
        c.reg_write   = 1'b1;
      end
      op_ori: begin
        c.alu_op      = alu_or;
        c.alu_src_imm = 1'b1;
        c.reg_write   = 1'b1;
      end
      op_lw: begin
        c.alu_src_imm = 1'b1;
        c.reg_write   = 1'b1;
        c.mem_read    = 1'b1;
      end
      op_sw: begin
        c.alu_src_imm = 1'b1;
        c.mem_write   = 1'b1;
      end
      op_beq:  c.branch_eq = 1'b1;
      op_bne:  c.branch_ne = 1'b1;
      op_jmp:  c.jump = 1'b1;
      op_halt: c.halt = 1'b1;
      default: c = c;
    endcase
    return c;
  endfunction

  assign ctrl = decode_ctrl(opcode);

  //////////////////////////////////////////////////
  // register file
  //////////////////////////////////////////////////

  // r0 stays zero, same-cycle writeback bypassed to the read
  function automatic data_t read_reg(reg_idx_t idx);
    if (idx == '0) begin
      return '0;
    end else if (wb.valid && wb.dst == idx) begin
      return wb.data;
    end
    return regs[idx];
  endfunction

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wb.valid && wb.dst != '0) begin
      regs[wb.dst] <= wb.data;
    end
  end

  // load-use hazard against the instruction now in execute
  assign stall = if_id.valid && id_ex.valid && id_ex.ctrl.mem_read &&
                 id_ex.dst != '0 && (id_ex.dst == rs || id_ex.dst == rt);

  assign is_halt   = if_id.valid && ctrl.halt;
  assign halt_seen = halt_q || is_halt;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      halt_q <= 1'b0;
    end else if (is_halt && !stall && !redirect.taken) begin
      halt_q <= 1'b1;
    end
  end

  always_comb begin
    id_ex_d         = '0;
    id_ex_d.valid   = if_id.valid;
    id_ex_d.ctrl    = ctrl;
    id_ex_d.rs      = rs;
    id_ex_d.rt      = rt;
    // R form writes rd, everything else rt
    id_ex_d.dst     = (ctrl.reg_write && !ctrl.alu_src_imm) ? rd : rt;
    id_ex_d.rs_data = read_reg(rs);
    id_ex_d.rt_data = read_reg(rt);
    id_ex_d.imm     = if_id.instr[15:0];
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      id_ex <= '0;
    end else begin
      id_ex <= id_ex_d;
      if (stall || redirect.taken) begin
        id_ex.valid <= 1'b0;
      end
    end
  end

endmodule

//--- execute/execute_stage.sv
module execute_stage import cpu_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  id_ex_t    id_ex,
  output ex_mem_t   ex_mem,
  input  retire_t   wb,
  output redirect_t redirect
);

  fwd_sel_e sel_a;
  fwd_sel_e sel_b;
  data_t    op_a;
  data_t    op_b_reg;
  data_t    op_b;
  data_t    alu_result;
  logic     equal;
  ex_mem_t  ex_mem_d;

  //////////////////////////////////////////////////
  // forwarding
  //////////////////////////////////////////////////

  // the younger producer in ex/mem wins over writeback
  function automatic fwd_sel_e pick_fwd(reg_idx_t src);
    if (ex_mem.valid && ex_mem.ctrl.reg_write && ex_mem.dst != '0 &&
        ex_mem.dst == src) begin
      return fwd_ex_mem;
    end else if (wb.valid && wb.dst == src) begin
      return fwd_mem_wb;
    end
    return fwd_reg;
  endfunction

  function automatic data_t fwd_mux(fwd_sel_e sel, data_t reg_val);
    case (sel)
      fwd_ex_mem: return ex_mem.alu_result;
      fwd_mem_wb: return wb.data;
      default:    return reg_val;
    endcase
  endfunction

  assign sel_a    = pick_fwd(id_ex.rs);
  assign sel_b    = pick_fwd(id_ex.rt);
  assign op_a     = fwd_mux(sel_a, id_ex.rs_data);
  assign op_b_reg = fwd_mux(sel_b, id_ex.rt_data);

  // immediates are zero-extended
  assign op_b = id_ex.ctrl.alu_src_imm ? {16'h0000, id_ex.imm} : op_b_reg;

  //////////////////////////////////////////////////
  // alu and branch
  //////////////////////////////////////////////////

  always_comb begin
    case (id_ex.ctrl.alu_op)
      alu_sub: alu_result = op_a - op_b;
      alu_and: alu_result = op_a & op_b;
      alu_or:  alu_result = op_a | op_b;
      alu_slt: alu_result = data_t'($signed(op_a) < $signed(op_b));
      default: alu_result = op_a + op_b;
    endcase
  end

  assign equal = (op_a == op_b_reg);

  assign redirect.taken  = id_ex.valid &&
                           (id_ex.ctrl.jump ||
                            (id_ex.ctrl.branch_eq && equal) ||
                            (id_ex.ctrl.branch_ne && !equal));
  assign redirect.target = addr_t'(id_ex.imm);

  always_comb begin
    ex_mem_d                = '0;
    ex_mem_d.valid          = id_ex.valid;
    ex_mem_d.ctrl.reg_write = id_ex.ctrl.reg_write;
    ex_mem_d.ctrl.mem_read  = id_ex.ctrl.mem_read;
    ex_mem_d.ctrl.mem_write = id_ex.ctrl.mem_write;
    ex_mem_d.ctrl.halt      = id_ex.ctrl.halt;
    ex_mem_d.dst            = id_ex.dst;
    ex_mem_d.alu_result     = alu_result;
    ex_mem_d.store_data     = op_b_reg;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ex_mem <= '0;
    end else begin
      ex_mem <= ex_mem_d;
    end
  end

endmodule

//--- src/memory_stage.sv
module memory_stage import cpu_pkg::*; #(
  parameter int DMEM_DEPTH = 256
) (
  input  logic    clk,
  input  logic    rst_n,
  input  ex_mem_t ex_mem,
  output retire_t retire,
  output logic    halted
);

  localparam int DMEM_AW = $clog2(DMEM_DEPTH);

  data_t dmem [DMEM_DEPTH];
  data_t load_data;
  logic  [DMEM_AW-1:0] dmem_addr;

  assign dmem_addr = ex_mem.alu_result[DMEM_AW-1:0];

  //////////////////////////////////////////////////
  // data memory
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < DMEM_DEPTH; i++) begin
        dmem[i] <= '0;
      end
    end else if (ex_mem.valid && ex_mem.ctrl.mem_write) begin
      dmem[dmem_addr] <= ex_mem.store_data;
    end
  end

  assign load_data = dmem[dmem_addr];

  // mem/wb with writeback select, r0 never retires
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      retire <= '0;
      halted <= 1'b0;
    end else begin
      retire.valid <= ex_mem.valid && ex_mem.ctrl.reg_write && ex_mem.dst != '0;
      retire.dst   <= ex_mem.dst;
      retire.data  <= ex_mem.ctrl.mem_read ? load_data : ex_mem.alu_result;
      if (ex_mem.valid && ex_mem.ctrl.halt) begin
        halted <= 1'b1;
      end
    end
  end

endmodule

//--- src/cpu_core.sv
module cpu_core import cpu_pkg::*; #(
  parameter int IMEM_DEPTH = 256,
  parameter int DMEM_DEPTH = 256
) (
  input  logic    clk,
  input  logic    rst_n,
  input  logic    imem_we,
  input  addr_t   imem_addr,
  input  instr_t  imem_wdata,
  output retire_t retire,
  output logic    halted
);

  if_id_t    if_id;
  id_ex_t    id_ex;
  ex_mem_t   ex_mem;
  redirect_t redirect;
  logic      stall;
  logic      halt_seen;

  fetch_stage #(
    .IMEM_DEPTH(IMEM_DEPTH)
  ) u_fetch_stage (
    .clk       (clk),
    .rst_n     (rst_n),
    .imem_we   (imem_we),
    .imem_addr (imem_addr),
    .imem_wdata(imem_wdata),
    .stall     (stall),
    .redirect  (redirect),
    .halt_seen (halt_seen),
    .if_id     (if_id)
  );

  decode_stage u_decode_stage (
    .clk      (clk),
    .rst_n    (rst_n),
    .if_id    (if_id),
    .wb       (retire),
    .redirect (redirect),
    .id_ex    (id_ex),
    .stall    (stall),
    .halt_seen(halt_seen)
  );

  execute_stage u_execute_stage (
    .clk     (clk),
    .rst_n   (rst_n),
    .id_ex   (id_ex),
    .ex_mem  (ex_mem),
    .wb      (retire),
    .redirect(redirect)
  );

  memory_stage #(
    .DMEM_DEPTH(DMEM_DEPTH)
  ) u_memory_stage (
    .clk   (clk),
    .rst_n (rst_n),
    .ex_mem(ex_mem),
    .retire(retire),
    .halted(halted)
  );

endmodule

//--- testbench/tb_ref_model.svh
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

//////////////////////////////////////////////////
// instruction encoders
//////////////////////////////////////////////////

function automatic instr_t enc_r(opcode_e op, int rd, int rs, int rt);
  return {op, reg_idx_t'(rs), reg_idx_t'(rt), reg_idx_t'(rd), 11'd0};
endfunction

// I form, also used for lw/sw (rt = data reg) and branches (imm = target)
function automatic instr_t enc_i(opcode_e op, int rt, int rs, int imm);
  return {op, reg_idx_t'(rs), reg_idx_t'(rt), imm_t'(imm)};
endfunction

function automatic int rnd_reg();
  return int'($urandom_range(7, 1));
endfunction

// 30 or so ALU and immediate ops over r1..r7, then halt
function automatic void build_random_prog(int n);
  opcode_e op;
  prog.delete();
  for (int i = 0; i < n; i++) begin
    op = opcode_e'($urandom_range(7, 1));
    if (op == op_addi || op == op_ori) begin
      prog.push_back(enc_i(op, rnd_reg(), rnd_reg(), int'($urandom_range(16'hffff))));
    end else begin
      prog.push_back(enc_r(op, rnd_reg(), rnd_reg(), rnd_reg()));
    end
  end
  prog.push_back(enc_i(op_halt, 0, 0, 0));
endfunction

//////////////////////////////////////////////////
// reference ISA model
//////////////////////////////////////////////////

// runs prog in order up to halt and fills exp_q with the register writes
function automatic void ref_run();
  data_t    r [32];
  data_t    mem [256];
  int       pc;
  logic     done;
  instr_t   w;
  opcode_e  op;
  data_t    a;
  data_t    b;
  data_t    zimm;
  data_t    res;
  reg_idx_t wdst;
  exp_q.delete();
  foreach (r[i]) r[i] = '0;
  foreach (mem[i]) mem[i] = '0;
  pc   = 0;
  done = 1'b0;
  for (int steps = 0; steps < 1000 && !done && pc < prog.size(); steps++) begin
    w    = prog[pc];
    op   = opcode_e'(w[31:26]);
    a    = r[w[25:21]];
    b    = r[w[20:16]];
    zimm = {16'h0000, w[15:0]};
    wdst = (op inside {op_add, op_sub, op_and, op_or, op_slt}) ? w[15:11] : w[20:16];
    res  = '0;
    pc   = pc + 1;
    case (op)
      op_add:  res = a + b;
      op_sub:  res = a - b;
      op_and:  res = a & b;
      op_or:   res = a | b;
      op_slt:  res = data_t'($signed(a) < $signed(b));
      op_addi: res = a + zimm;
      op_ori:  res = a | zimm;
      op_lw:   res = mem[8'(a + zimm)];
      op_sw:   mem[8'(a + zimm)] = b;
      op_beq:  pc = (a == b) ? int'(w[15:0]) : pc;
      op_bne:  pc = (a != b) ? int'(w[15:0]) : pc;
      op_jmp:  pc = int'(w[15:0]);
      op_halt: done = 1'b1;
      default: res = '0;
    endcase
    if (op inside {op_add, op_sub, op_and, op_or, op_slt, op_addi, op_ori, op_lw} &&
        wdst != '0) begin
      exp_q.push_back('{valid: 1'b1, dst: wdst, data: res});
      r[wdst] = res;
    end
  end
endfunction

`endif

//--- testbench/cpu_tb.sv
module cpu_tb import cpu_pkg::*; ();

  localparam int CLK_PERIOD = 40;
  localparam int RST_CYCLES = 3;
  localparam int NUM_RANDOM = 10;

  logic    clk;
  logic    rst_n;
  logic    imem_we;
  addr_t   imem_addr;
  instr_t  imem_wdata;
  retire_t retire;
  logic    halted;

  instr_t  prog [$];
  retire_t exp_q [$];
  logic    checking;
  int      got;
  int      test_errs;
  int      total_errs;
  int      checks;
  int      tests;
  int      fails;
  int      run_cycles;
  int      budget;

  `include "tb_ref_model.svh"

  cpu_core #(
    .IMEM_DEPTH(256),
    .DMEM_DEPTH(256)
  ) u_cpu_core (
    .clk       (clk),
    .rst_n     (rst_n),
    .imem_we   (imem_we),
    .imem_addr (imem_addr),
    .imem_wdata(imem_wdata),
    .retire    (retire),
    .halted    (halted)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  //////////////////////////////////////////////////
  // compare and watchdog
  //////////////////////////////////////////////////

  always @(negedge clk) begin
    if (checking && retire.valid) begin
      if (got < exp_q.size()) begin
        checks++;
        if (retire.dst !== exp_q[got].dst) begin
          $display("Mismatch retire.dst at write %0d: got %h expected %h",
                   got, retire.dst, exp_q[got].dst);
          test_errs++;
        end
        if (retire.data !== exp_q[got].data) begin
          $display("Mismatch retire.data at write %0d: got %h expected %h",
                   got, retire.data, exp_q[got].data);
          test_errs++;
        end
      end
      got++;
    end
  end

  always @(negedge clk) begin
    if (checking) begin
      run_cycles++;
      if (run_cycles > budget) begin
        $display("Timeout: program did not halt within %0d cycles", budget);
        $display("STATUS: FAIL");
        $finish;
      end
    end
  end

  //////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////

  task automatic run_test(input string name);
    ref_run();
    budget = 6 * prog.size() + 50;
    @(posedge clk);
    rst_n <= 1'b0;
    // program goes in while the core is held in reset
    foreach (prog[i]) begin
      @(posedge clk);
      imem_we    <= 1'b1;
      imem_addr  <= addr_t'(i);
      imem_wdata <= prog[i];
    end
    @(posedge clk);
    imem_we <= 1'b0;
    repeat (RST_CYCLES) @(posedge clk);
    rst_n      <= 1'b1;
    got        = 0;
    test_errs  = 0;
    run_cycles = 0;
    checking   = 1'b1;
    while (halted !== 1'b1) @(negedge clk);
    // every write older than the halt is in by the time halted rises
    @(posedge clk);
    if (got < exp_q.size()) begin
      $display("test %s: halted after only %0d of %0d expected writes", name, got,
               exp_q.size());
      test_errs++;
    end
    // anything after the halt must stay quiet
    repeat (8) @(posedge clk);
    checking = 1'b0;
    if (got > exp_q.size()) begin
      $display("test %s: %0d writes retired but %0d expected", name, got, exp_q.size());
      test_errs++;
    end
    tests++;
    total_errs += test_errs;
    if (test_errs == 0) begin
      $display("test %s: ok, %0d writes retired", name, got);
    end else begin
      $display("test %s: failed with %0d errors", name, test_errs);
      fails++;
    end
  endtask

  initial begin
    rst_n      = 1'b0;
    imem_we    = 1'b0;
    imem_addr  = '0;
    imem_wdata = '0;
    checking   = 1'b0;
    got        = 0;
    test_errs  = 0;
    total_errs = 0;
    checks     = 0;
    tests      = 0;
    fails      = 0;
    run_cycles = 0;
    budget     = 0;
    void'($urandom(89267));

    // straight-line ALU with slt on negative values
    prog = '{enc_i(op_addi, 1, 0, 25), enc_i(op_addi, 2, 0, 7), enc_i(op_ori, 3, 0, 16'hf0f0),
             enc_r(op_add, 4, 1, 2), enc_r(op_sub, 5, 2, 1), enc_r(op_and, 6, 3, 1),
             enc_r(op_or, 7, 3, 2), enc_r(op_slt, 8, 5, 2), enc_r(op_slt, 9, 2, 5),
             enc_r(op_slt, 10, 5, 0), enc_i(op_halt, 0, 0, 0)};
    run_test("alu");

    // dependencies at distance 1, 2 and 3
    prog = '{enc_i(op_addi, 1, 0, 5), enc_r(op_add, 2, 1, 1), enc_i(op_addi, 3, 0, 3),
             enc_i(op_nop, 0, 0, 0), enc_r(op_add, 4, 3, 2), enc_i(op_addi, 5, 0, 1),
             enc_i(op_nop, 0, 0, 0), enc_i(op_nop, 0, 0, 0), enc_r(op_sub, 6, 4, 5),
             enc_r(op_add, 7, 6, 6), enc_i(op_halt, 0, 0, 0)};
    run_test("forward");

    // store then load with the loaded value used at once
    prog = '{enc_i(op_addi, 1, 0, 100), enc_i(op_addi, 2, 0, 8), enc_i(op_sw, 1, 2, 4),
             enc_i(op_lw, 3, 2, 4), enc_r(op_add, 4, 3, 3), enc_i(op_lw, 5, 0, 12),
             enc_i(op_sw, 5, 0, 0), enc_i(op_lw, 6, 0, 0), enc_r(op_sub, 7, 6, 1),
             enc_i(op_halt, 0, 0, 0)};
    run_test("load_use");

    // taken and untaken branches and a jmp where flushed slots hold 99
    prog = '{enc_i(op_addi, 1, 0, 4), enc_i(op_addi, 2, 0, 4), enc_i(op_beq, 2, 1, 5),
             enc_i(op_addi, 3, 0, 99), enc_i(op_addi, 4, 0, 99), enc_i(op_bne, 2, 1, 8),
             enc_i(op_addi, 5, 0, 11), enc_i(op_jmp, 0, 0, 10), enc_i(op_addi, 6, 0, 99),
             enc_i(op_addi, 7, 0, 99), enc_i(op_bne, 0, 1, 13), enc_i(op_addi, 3, 0, 99),
             enc_i(op_addi, 4, 0, 99), enc_i(op_beq, 1, 5, 15), enc_i(op_addi, 8, 0, 22),
             enc_i(op_halt, 0, 0, 0)};
    run_test("branch");

    // r0 writes and reads plus code past the halt
    prog = '{enc_i(op_addi, 0, 0, 55), enc_i(op_addi, 1, 0, 9), enc_r(op_or, 0, 1, 1),
             enc_r(op_add, 2, 0, 1), enc_i(op_halt, 0, 0, 0), enc_i(op_addi, 3, 0, 1),
             enc_i(op_addi, 4, 0, 2)};
    run_test("r0_halt");

    for (int t = 0; t < NUM_RANDOM; t++) begin
      build_random_prog(30);
      run_test($sformatf("random_%0d", t));
    end

    $display("tests %0d, failed %0d, checks %0d, errors %0d", tests, fails, checks, total_errs);
    if (total_errs == 0 && fails == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

//--- project.f
+incdir+testbench
common/cpu_pkg.sv
fetch/fetch_stage.sv
decode/decode_stage.sv
execute/execute_stage.sv
src/memory_stage.sv
src/cpu_core.sv
testbench/cpu_tb.sv

//--- Makefile
# Verilator build and run for the pipelined core

VERILATOR ?= verilator
TOP       ?= cpu_tb
LOG       ?= sim.log
SEED      ?= 1
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run $(TOP), check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP LOG SEED FILELIST BUILD_DIR"

test:
	$(VERILATOR) --binary --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) +verilator+seed+$(SEED) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "STATUS: PASS" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
